//--- src/snow_settings.svh
// Screen, colour, border, pellet grid and snowflake constants for the snow overlay
`ifndef SNOW_SETTINGS_SVH
`define SNOW_SETTINGS_SVH

// Visible raster
`define SNOW_SCREEN_W 1920
`define SNOW_SCREEN_H 1080
`define SNOW_X_W 12                  // Column counter width
`define SNOW_Y_W 11                  // Row counter width

// Colours as 24-bit RGB words
`define SNOW_COLOR_BORDER 24'h00_40_80
`define SNOW_COLOR_WHITE 24'hFF_FF_FF
`define SNOW_COLOR_BG 24'h00_00_00

// Double-line border, distances from the screen edge
`define SNOW_BORDER_OUTER 15
`define SNOW_BORDER_GAP 10
`define SNOW_BORDER_INNER 5

// Pellet grid
`define SNOW_DOT_PITCH 50
`define SNOW_DOT_LO 22               // Pellet start inside a pitch cell
`define SNOW_DOT_HI 28               // Pellet end, exclusive
`define SNOW_DOT_X_MIN 80
`define SNOW_DOT_X_MAX 1840
`define SNOW_DOT_Y_MIN 80
`define SNOW_DOT_Y_MAX 1000

// Snowflakes
`define SNOW_NUM_FLAKES 12
`define SNOW_FLAKE_HALF 8
`define SNOW_FLAKE_ARM 2
`define SNOW_FLAKE_X_STEP 160        // Reset spacing in x
`define SNOW_FLAKE_Y_STEP 90         // Reset spacing in y
`define SNOW_WRAP_SHIFT 137          // Column shift on wrap to top

`endif

//--- src/snow_pkg.sv
// Package with the video, position, snowflake and layer struct types
`include "snow_settings.svh"

package snow_pkg;

    // One pixel colour
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    // Blanking levels, high while blanked
    typedef struct packed {
        logic v;
        logic h;
    } vid_blank_t;

    // Sync bits as passed through to the output
    typedef struct packed {
        logic d;                         // Data enable style sync
        logic v;
        logic h;
    } vid_sync_t;

    // Raster position of the current pixel
    typedef struct packed {
        logic [`SNOW_X_W-1:0] x;
        logic [`SNOW_Y_W-1:0] y;
    } pix_pos_t;

    // One snowflake record
    typedef struct packed {
        logic [10:0] x;                  // Centre column
        logic [10:0] y;                  // Centre row
        logic [3:0]  speed;              // Rows per frame
    } flake_t;

    typedef flake_t [`SNOW_NUM_FLAKES-1:0] flake_arr_t;

    // Per pixel layer coverage
    typedef struct packed {
        logic snow;
        logic border;
        logic dot;
    } layer_hits_t;

endpackage

//--- src/raster_tracker.sv
// Blank edge detector with pixel column and row counters and frame start strobe
`timescale 1ns/1ps
`include "snow_settings.svh"

module raster_tracker (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   cen_i,          // Pixel enable
    input  snow_pkg::vid_blank_t   blank_i,
    output snow_pkg::pix_pos_t     pos_o,
    output logic                   frame_start_o   // One cycle at start of visible frame
);

    snow_pkg::vid_blank_t blank_d;             // Blank levels from previous enabled edge
    snow_pkg::pix_pos_t   pos_q;
    logic                 h_fall;
    logic                 h_rise;
    logic                 v_fall;

    // Edges against the delayed levels
    assign h_fall = blank_d.h & ~blank_i.h;    // Leaving line blank
    assign h_rise = ~blank_d.h & blank_i.h;    // Entering line blank
    assign v_fall = blank_d.v & ~blank_i.v;    // Leaving frame blank

    assign frame_start_o = cen_i & v_fall;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            blank_d <= '0;
            pos_q   <= '0;
        end else if (cen_i) begin
            blank_d <= blank_i;

            // Column counter
            if (h_fall) begin
                pos_q.x <= '0;                 // First visible pixel of the line
            end else if (!blank_i.h) begin
                pos_q.x <= pos_q.x + 1'b1;
            end

            // Row counter, steps at the end of each line
            if (v_fall) begin
                pos_q.y <= '0;
            end else if (h_rise) begin
                pos_q.y <= pos_q.y + 1'b1;
            end
        end
    end

    assign pos_o = pos_q;

endmodule

//--- src/snowfall_state.sv
// Snowflake record storage with per frame fall and wrap to the top
`timescale 1ns/1ps
`include "snow_settings.svh"

module snowfall_state (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   cen_i,
    input  logic                   frame_start_i,  // Already qualified with cen_i
    output snow_pkg::flake_arr_t   flakes_o
);

    snow_pkg::flake_arr_t flakes_q;
    snow_pkg::flake_arr_t flakes_next;

    // Move one flake down by its speed, wrap at the bottom
    function automatic snow_pkg::flake_t move_flake(input snow_pkg::flake_t f);
        snow_pkg::flake_t res;
        logic [11:0]      y_sum;
        logic [11:0]      x_sum;
        begin
            res   = f;
            y_sum = {1'b0, f.y} + {8'd0, f.speed};
            x_sum = {1'b0, f.x} + 12'(`SNOW_WRAP_SHIFT);
            if (y_sum >= 12'(`SNOW_SCREEN_H)) begin
                res.y = '0;                        // Back to the top
                if (x_sum >= 12'(`SNOW_SCREEN_W)) begin
                    x_sum = x_sum - 12'(`SNOW_SCREEN_W);  // Modulo screen width
                end
                res.x = x_sum[10:0];
            end else begin
                res.y = y_sum[10:0];
            end
            return res;
        end
    endfunction

    always_comb begin
        for (int i = 0; i < `SNOW_NUM_FLAKES; i++) begin
            flakes_next[i] = move_flake(flakes_q[i]);
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            // Staggered start pattern
            for (int j = 0; j < `SNOW_NUM_FLAKES; j++) begin
                flakes_q[j].x     <= 11'((j * `SNOW_FLAKE_X_STEP) % `SNOW_SCREEN_W);
                flakes_q[j].y     <= 11'((j * `SNOW_FLAKE_Y_STEP) % `SNOW_SCREEN_H);
                flakes_q[j].speed <= 4'((j % 8) + 1);     // Speeds 1 to 8
            end
        end else if (cen_i && frame_start_i) begin
            flakes_q <= flakes_next;               // Same edge that clears the row
        end
    end

    assign flakes_o = flakes_q;

endmodule

//--- src/scene_painter.sv
// Per pixel coverage of border rings, pellet grid and snowflakes
`timescale 1ns/1ps
`include "snow_settings.svh"

module scene_painter (
    input  snow_pkg::pix_pos_t     pos_i,
    input  snow_pkg::flake_arr_t   flakes_i,
    output snow_pkg::layer_hits_t  hits_o
);

    localparam int RING_LO = `SNOW_BORDER_OUTER + `SNOW_BORDER_GAP;  // Inner ring start
    localparam int RING_HI = RING_LO + `SNOW_BORDER_INNER;           // Inner ring end

    logic [`SNOW_X_W-1:0] dist_x;      // To nearest left or right edge
    logic [`SNOW_Y_W-1:0] dist_y;      // To nearest top or bottom edge
    logic [`SNOW_X_W-1:0] dist_min;
    logic                 outer_hit;
    logic                 inner_hit;
    logic [5:0]           x_mod;
    logic [5:0]           y_mod;
    logic                 in_field;
    logic                 snow_any;

    // Snowflake shape around one centre
    function automatic logic flake_hit(input snow_pkg::pix_pos_t p,
                                       input snow_pkg::flake_t f);
        logic [11:0] ax;
        logic [10:0] ay;
        logic [12:0] diag;
        logic        near;
        logic        shape;
        begin
            ax   = (p.x >= {1'b0, f.x}) ? p.x - {1'b0, f.x} : {1'b0, f.x} - p.x;
            ay   = (p.y >= f.y) ? p.y - f.y : f.y - p.y;
            diag = {1'b0, ax} + {2'b0, ay};
            near = (ax <= `SNOW_FLAKE_HALF) && (ay <= `SNOW_FLAKE_HALF);
            shape = (ax < `SNOW_FLAKE_ARM && ay < `SNOW_FLAKE_ARM)       // Centre
                 || (ay < `SNOW_FLAKE_ARM && ax < `SNOW_FLAKE_HALF)      // Horizontal arm
                 || (ax < `SNOW_FLAKE_ARM && ay < `SNOW_FLAKE_HALF)      // Vertical arm
                 || (ax == {1'b0, ay} && ax < `SNOW_FLAKE_HALF)          // Diagonals
                 || (diag < 3);                                          // Small diamond
            return near && shape;
        end
    endfunction

    // Edge distances, folded at the screen centre
    assign dist_x = (pos_i.x < `SNOW_SCREEN_W / 2) ? pos_i.x
                  : `SNOW_X_W'(`SNOW_SCREEN_W - 1) - pos_i.x;
    assign dist_y = (pos_i.y < `SNOW_SCREEN_H / 2) ? pos_i.y
                  : `SNOW_Y_W'(`SNOW_SCREEN_H - 1) - pos_i.y;
    assign dist_min = (dist_x < {1'b0, dist_y}) ? dist_x : {1'b0, dist_y};

    assign outer_hit = dist_min < `SNOW_BORDER_OUTER;
    // Inner ring, one axis in the band and the other clear of the gap
    assign inner_hit = (dist_x >= RING_LO && dist_x < RING_HI && dist_y >= RING_LO)
                    || (dist_y >= RING_LO && dist_y < RING_HI && dist_x >= RING_LO);

    // Pellet grid
    assign x_mod    = 6'(pos_i.x % `SNOW_DOT_PITCH);
    assign y_mod    = 6'(pos_i.y % `SNOW_DOT_PITCH);
    assign in_field = (pos_i.x >= `SNOW_DOT_X_MIN) && (pos_i.x < `SNOW_DOT_X_MAX)
                   && (pos_i.y >= `SNOW_DOT_Y_MIN) && (pos_i.y < `SNOW_DOT_Y_MAX);

    // Any of the flakes
    always_comb begin
        snow_any = 1'b0;
        for (int i = 0; i < `SNOW_NUM_FLAKES; i++) begin
            snow_any = snow_any | flake_hit(pos_i, flakes_i[i]);
        end
    end

    assign hits_o.snow   = snow_any;
    assign hits_o.border = outer_hit | inner_hit;
    assign hits_o.dot    = in_field
                        && (x_mod >= `SNOW_DOT_LO) && (x_mod < `SNOW_DOT_HI)
                        && (y_mod >= `SNOW_DOT_LO) && (y_mod < `SNOW_DOT_HI);

endmodule

//--- src/pixel_output.sv
// Layer compositing with the output colour and sync register
`timescale 1ns/1ps
`include "snow_settings.svh"

module pixel_output (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   cen_i,
    input  snow_pkg::layer_hits_t  hits_i,
    input  snow_pkg::vid_sync_t    sync_i,
    output snow_pkg::rgb_t         rgb_o,
    output snow_pkg::vid_sync_t    sync_o
);

    snow_pkg::rgb_t      rgb_next;
    snow_pkg::rgb_t      rgb_q;
    snow_pkg::vid_sync_t sync_q;

    // Top layer wins, dots end up hidden under the border
    always_comb begin
        if (hits_i.snow) begin
            rgb_next = snow_pkg::rgb_t'(`SNOW_COLOR_WHITE);
        end else if (hits_i.border) begin
            rgb_next = snow_pkg::rgb_t'(`SNOW_COLOR_BORDER);
        end else if (hits_i.dot) begin
            rgb_next = snow_pkg::rgb_t'(`SNOW_COLOR_WHITE);
        end else begin
            rgb_next = snow_pkg::rgb_t'(`SNOW_COLOR_BG);
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rgb_q  <= '0;
            sync_q <= '0;
        end else if (cen_i) begin
            rgb_q  <= rgb_next;
            sync_q <= sync_i;              // Keeps sync aligned with colour
        end
    end

    assign rgb_o  = rgb_q;
    assign sync_o = sync_q;

endmodule

//--- src/snow_scene_top.sv
// Top level of the snow overlay, raster tracker, snowfall, painter and output stage
`timescale 1ns/1ps

module snow_scene_top (
    input  logic                   clk_i,
    input  logic                   cen_i,      // Pixel enable
    input  logic                   rst_i,
    input  snow_pkg::vid_blank_t   blank_i,
    input  snow_pkg::vid_sync_t    sync_i,
    output snow_pkg::vid_sync_t    sync_o,     // One enabled edge late
    output snow_pkg::rgb_t         rgb_o
);

    snow_pkg::pix_pos_t    pos;
    logic                  frame_start;
    snow_pkg::flake_arr_t  flakes;
    snow_pkg::layer_hits_t hits;

    raster_tracker raster_tracker_i (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .cen_i         (cen_i),
        .blank_i       (blank_i),
        .pos_o         (pos),
        .frame_start_o (frame_start)
    );

    snowfall_state snowfall_state_i (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .cen_i         (cen_i),
        .frame_start_i (frame_start),
        .flakes_o      (flakes)
    );

    scene_painter scene_painter_i (
        .pos_i         (pos),
        .flakes_i      (flakes),
        .hits_o        (hits)
    );

    pixel_output pixel_output_i (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .cen_i         (cen_i),
        .hits_i        (hits),
        .sync_i        (sync_i),
        .rgb_o         (rgb_o),
        .sync_o        (sync_o)
    );

endmodule

//--- test/snow_scene_model.svh
// Reference model of raster counters, snowflake fall and layer priority
`ifndef SNOW_SCENE_MODEL_SVH
`define SNOW_SCENE_MODEL_SVH

int                  mx, my;                   // Column and row counters
logic                prev_h, prev_v;           // Blank levels at the last enabled edge
int                  fx[`SNOW_NUM_FLAKES];
int                  fy[`SNOW_NUM_FLAKES];
int                  fs[`SNOW_NUM_FLAKES];     // Speeds
snow_pkg::rgb_t      exp_rgb;
snow_pkg::vid_sync_t exp_sync;
logic                rgb_known;                // Colour belongs to a visible pixel

// Row after one frame of fall, zero on wrap
function automatic int fall_y(input int y, input int s);
    return (y + s >= `SNOW_SCREEN_H) ? 0 : y + s;
endfunction

// Column after one frame, shifted only on wrap
function automatic int wrap_x(input int x, input int y, input int s);
    return (y + s >= `SNOW_SCREEN_H) ? (x + `SNOW_WRAP_SHIFT) % `SNOW_SCREEN_W : x;
endfunction

function automatic snow_pkg::rgb_t colour_at(input int x, input int y);
    int   dx, dy, d, ax, ay;
    logic snow, border, dot;
    dx = (x < `SNOW_SCREEN_W - 1 - x) ? x : `SNOW_SCREEN_W - 1 - x;
    dy = (y < `SNOW_SCREEN_H - 1 - y) ? y : `SNOW_SCREEN_H - 1 - y;
    d  = (dx < dy) ? dx : dy;
    border = (d < 15) || (dx >= 25 && dx < 30 && dy >= 25)
          || (dy >= 25 && dy < 30 && dx >= 25);       // Outer ring, then inner ring
    dot = x >= 80 && x < 1840 && y >= 80 && y < 1000
       && x % 50 >= 22 && x % 50 < 28 && y % 50 >= 22 && y % 50 < 28;
    snow = 1'b0;
    for (int j = 0; j < `SNOW_NUM_FLAKES; j++) begin
        ax = (x > fx[j]) ? x - fx[j] : fx[j] - x;
        ay = (y > fy[j]) ? y - fy[j] : fy[j] - y;
        if (ax <= 8 && ay <= 8 && ((ax < 2 && ay < 2) || (ay < 2 && ax < 8)
                || (ax < 2 && ay < 8) || (ax == ay && ax < 8) || (ax + ay < 3))) begin
            snow = 1'b1;
        end
    end
    if (snow || (!border && dot)) begin
        return snow_pkg::rgb_t'(`SNOW_COLOR_WHITE);
    end
    return border ? snow_pkg::rgb_t'(`SNOW_COLOR_BORDER) : snow_pkg::rgb_t'(`SNOW_COLOR_BG);
endfunction

task automatic reset_model();
    mx        = 0;
    my        = 0;
    prev_h    = 1'b0;
    prev_v    = 1'b0;
    exp_rgb   = '0;
    exp_sync  = '0;
    rgb_known = 1'b1;
    for (int j = 0; j < `SNOW_NUM_FLAKES; j++) begin
        fx[j] = (j * 160) % `SNOW_SCREEN_W;
        fy[j] = (j * 90) % `SNOW_SCREEN_H;
        fs[j] = (j % 8) + 1;
    end
endtask

// One clock edge, state moves only when enabled
task automatic advance_model(input logic cen, input snow_pkg::vid_blank_t b,
                             input snow_pkg::vid_sync_t s);
    logic v_fall;
    if (cen) begin
        v_fall    = prev_v && !b.v;
        exp_rgb   = colour_at(mx, my);             // Position before this edge
        rgb_known = (mx < `SNOW_SCREEN_W) && (my < `SNOW_SCREEN_H);
        exp_sync  = s;
        for (int j = 0; j < `SNOW_NUM_FLAKES && v_fall; j++) begin
            fx[j] = wrap_x(fx[j], fy[j], fs[j]);   // Uses the old row
            fy[j] = fall_y(fy[j], fs[j]);
        end
        if (prev_h && !b.h) begin
            mx = 0;
        end else if (!b.h) begin
            mx = (mx + 1) % (1 << `SNOW_X_W);
        end
        if (v_fall) begin
            my = 0;
        end else if (!prev_h && b.h) begin
            my = (my + 1) % (1 << `SNOW_Y_W);
        end
        prev_h = b.h;
        prev_v = b.v;
    end
endtask

`endif

//--- test/tb_snow_scene.sv
// Testbench for the snow overlay with random video timing checked against a model
`timescale 1ns/1ps
`include "snow_settings.svh"

module tb_snow_scene;

    localparam longint LINE_MAX = `SNOW_SCREEN_W + 8;     // Widest line plus blanking
    localparam longint EDGE_MAX = 2000 + 32 * (`SNOW_SCREEN_H + 4) * LINE_MAX;
    localparam longint WATCH_NS = 2 * 4 * EDGE_MAX * 20;  // At most 4 cycles per edge

    logic                 clk_i = 1'b0;
    logic                 cen_i;
    logic                 rst_i;
    snow_pkg::vid_blank_t blank_i;
    snow_pkg::vid_sync_t  sync_i;
    snow_pkg::vid_sync_t  sync_o;
    snow_pkg::rgb_t       rgb_o;
    integer               seed;
    int                   line_len[`SNOW_SCREEN_H];       // Visible width per row
    string                test_name;
    int                   checks, errors, tests, ck0, er0;
    logic                 check_on;

    `include "snow_scene_model.svh"

    snow_scene_top snow_scene_top_i (.*);

    always #10 clk_i = ~clk_i;

    // Model sees the inputs the DUT samples at this edge
    always @(posedge clk_i) begin
        if (rst_i) begin
            reset_model();
        end else begin
            advance_model(cen_i, blank_i, sync_i);
        end
    end

    always @(negedge clk_i) begin
        if (check_on) begin
            if (rgb_known) begin
                check_rgb(exp_rgb, rgb_o);     // Off-screen positions have no defined colour
            end
            check_sync(exp_sync, sync_o);
        end
    end

    task automatic check_rgb(input snow_pkg::rgb_t exp, input snow_pkg::rgb_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s rgb expected %h actual %h", test_name, exp, act);
        end
    endtask

    task automatic check_sync(input snow_pkg::vid_sync_t exp, input snow_pkg::vid_sync_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s sync expected %b actual %b", test_name, exp, act);
        end
    endtask

    // Held cycles now and then, random inputs while disabled
    task automatic drive_edge(input logic v, input logic h);
        int idle;
        idle = $random(seed) & 15;
        idle = (idle > 12) ? idle - 12 : 0;
        repeat (idle) begin
            @(posedge clk_i);
            cen_i   <= 1'b0;
            blank_i <= 2'($random(seed));
            sync_i  <= 3'($random(seed));
        end
        @(posedge clk_i);
        cen_i   <= 1'b1;
        blank_i <= {v, h};
        sync_i  <= 3'($random(seed));
    endtask

    // Negative rows are vertical blanking lines
    task automatic drive_frame(input int rows);
        int hb;
        for (int r = -(1 + ($random(seed) & 3)); r < rows; r++) begin
            hb = 1 + ($random(seed) & 7);
            repeat ((r < 0) ? 20 : line_len[r]) drive_edge(r < 0, 1'b0);
            repeat (hb) drive_edge(r < 0, 1'b1);
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        ck0       = checks;
        er0       = errors;
    endtask

    task automatic end_test();
        tests++;
        $display("%s finished, %0d checks, %0d errors", test_name, checks - ck0, errors - er0);
    endtask

    initial begin
        int w;
        seed     = 32'h307f0cad;
        cen_i    = 1'b0;
        rst_i    = 1'b1;
        blank_i  = '0;
        sync_i   = '0;
        checks   = 0;
        errors   = 0;
        tests    = 0;
        check_on = 1'b0;
        repeat (4) @(posedge clk_i);
        rst_i <= 1'b0;

        start_test("reset_hold");
        check_on = 1'b1;
        @(negedge clk_i);
        check_rgb('0, rgb_o);
        check_sync('0, sync_o);
        repeat (1 + ($random(seed) & 15)) begin
            @(posedge clk_i);                  // cen_i stays low
            blank_i <= 2'($random(seed));
            sync_i  <= 3'($random(seed));
        end
        repeat (40) drive_edge(1'b1, 1'b1);
        end_test();

        start_test("sync_delay");
        repeat (500) drive_edge(1'b1, 1'b1);
        end_test();

        start_test("raster_border");
        for (int r = 0; r < `SNOW_SCREEN_H; r++) begin
            line_len[r] = (r < 40 || r >= 1040) ? 1920 : 1 + ($random(seed) & 32'h7fff_ffff) % 300;
        end
        drive_frame(`SNOW_SCREEN_H);
        end_test();

        start_test("pellet_grid");
        for (int r = 0; r < 131; r++) begin
            line_len[r] = (r >= 80) ? 1920 : 1 + ($random(seed) & 31);
        end
        drive_frame(131);
        end_test();

        start_test("snowfall");
        for (int f = 0; f < 30; f++) begin
            for (int r = 0; r < `SNOW_SCREEN_H; r++) begin
                line_len[r] = 1 + ($random(seed) & 32'h7fff_ffff) % 40;
            end
            // Last frame widens the rows around each predicted flake
            for (int j = 0; j < `SNOW_NUM_FLAKES && f == 29; j++) begin
                w = wrap_x(fx[j], fy[j], fs[j]) + 9;
                w = (w > 1920) ? 1920 : w;
                for (int r = fall_y(fy[j], fs[j]) - 8; r <= fall_y(fy[j], fs[j]) + 8; r++) begin
                    if (r >= 0 && r < `SNOW_SCREEN_H && line_len[r] < w) begin
                        line_len[r] = w;
                    end
                end
            end
            drive_frame(`SNOW_SCREEN_H);
        end
        end_test();

        repeat (2) @(posedge clk_i);           // Last driven edge checked at the negedge between
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Watchdog sized from the longest possible stimulus
    initial begin
        #(WATCH_NS);
        $display("Timeout, the tests were still running after %0d ns", WATCH_NS);
        $display("sim failed");
        $finish;
    end

endmodule

//--- all.f
+incdir+src
+incdir+test
src/snow_pkg.sv
src/raster_tracker.sv
src/snowfall_state.sv
src/scene_painter.sv
src/pixel_output.sv
src/snow_scene_top.sv
test/tb_snow_scene.sv

//--- Bender.yml
package:
  name: snow_scene

export_include_dirs:
  - src

sources:
  - src/snow_pkg.sv
  - src/raster_tracker.sv
  - src/snowfall_state.sv
  - src/scene_painter.sv
  - src/pixel_output.sv
  - src/snow_scene_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_snow_scene.sv
